// File: logic/ex_core_pkg.sv
package ex_core_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0.

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // Encoded as {funct7[5], funct3}.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        a_rs1 = 1'b0,
        a_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        b_i_imm = 3'd0,
        b_u_imm = 3'd1,
        b_b_imm = 3'd2,
        b_s_imm = 3'd3,
        b_rs2   = 3'd4
    } alumux2_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_pc4 = 2'd1,
        wb_cmp = 2'd2
    } wbmux_sel_t;

    typedef struct packed {
        logic [XLEN-1:0] i_imm;
        logic [XLEN-1:0] s_imm;
        logic [XLEN-1:0] b_imm;
        logic [XLEN-1:0] u_imm;
        logic [XLEN-1:0] j_imm;
    } imm_t;

    typedef struct packed {
        opcode_t         opcode;
        alu_op_t         alu_op;
        cmp_op_t         cmp_op;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        wbmux_sel_t      wbmux_sel;
        logic            is_branch;
        logic            is_jump;
        logic            reg_write;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [XLEN-1:0] pc;
    } ctrl_word_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } issue_t;

    typedef struct packed {
        logic            commit;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc_rdata;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [XLEN-1:0] rs1_rdata;
        logic [XLEN-1:0] rs2_rdata;
    } monitor_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] pc;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

// File: logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic [ex_core_pkg::XLEN-1:0] instr,
    input  logic [ex_core_pkg::XLEN-1:0] pc,
    output ex_core_pkg::ctrl_word_t      ctrl,
    output ex_core_pkg::imm_t            imm
);
    import ex_core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates, all formats.
    assign imm.i_imm = {{21{instr[31]}}, instr[30:20]};
    assign imm.s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm.b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm.u_imm = {instr[31:12], 12'h000};
    assign imm.j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl             = '0;
        ctrl.opcode      = opcode_t'(instr[6:0]);
        ctrl.rd          = instr[11:7];
        ctrl.funct3      = funct3;
        ctrl.funct7      = funct7;
        ctrl.pc          = pc;
        ctrl.alu_op      = alu_add;
        ctrl.cmp_op      = cmp_op_t'(funct3);
        ctrl.alumux1_sel = a_rs1;
        ctrl.alumux2_sel = b_i_imm;
        ctrl.cmpmux_sel  = cmp_rs2;
        ctrl.wbmux_sel   = wb_alu;

        case (opcode_t'(instr[6:0]))
            op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alumux2_sel = b_u_imm;
            end
            op_auipc: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alumux1_sel = a_pc;
                ctrl.alumux2_sel = b_u_imm;
            end
            op_jal, op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.wbmux_sel = wb_pc4; // Link value.
            end
            op_branch: begin
                ctrl.is_branch   = 1'b1;
                ctrl.alumux1_sel = a_pc;
                ctrl.alumux2_sel = b_b_imm;
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                // funct7 only qualifies the shift right here.
                if (funct3 == 3'b101) begin
                    ctrl.alu_op = alu_op_t'({funct7[5], funct3});
                end else begin
                    ctrl.alu_op = alu_op_t'({1'b0, funct3});
                end
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ctrl.wbmux_sel  = wb_cmp;
                    ctrl.cmpmux_sel = cmp_i_imm;
                    ctrl.cmp_op     = funct3[0] ? cmp_bltu : cmp_blt;
                end
            end
            op_reg: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alumux2_sel = b_rs2;
                ctrl.alu_op      = alu_op_t'({funct7[5], funct3});
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ctrl.wbmux_sel = wb_cmp;
                    ctrl.cmp_op    = funct3[0] ? cmp_bltu : cmp_blt;
                end
            end
            default: begin
                ctrl.reg_write = 1'b0; // Loads, stores, unknown.
            end
        endcase
    end

endmodule

// File: logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         advance,
    input  logic                         flush,
    input  ex_core_pkg::issue_t          issue,
    input  ex_core_pkg::ctrl_word_t      ctrl_in,
    input  ex_core_pkg::imm_t            imm_in,
    output ex_core_pkg::ctrl_word_t      ctrl,
    output ex_core_pkg::imm_t            imm,
    output logic [ex_core_pkg::XLEN-1:0] rs1_data,
    output logic [ex_core_pkg::XLEN-1:0] rs2_data,
    output logic                         valid,
    output ex_core_pkg::monitor_t        mon
);
    import ex_core_pkg::*;

    ctrl_word_t bubble_ctrl;

    // Control word of the NOP that a flush leaves behind.
    always_comb begin
        bubble_ctrl             = '0;
        bubble_ctrl.opcode      = opcode_t'(NOP_INSTR[6:0]);
        bubble_ctrl.rd          = NOP_INSTR[11:7];
        bubble_ctrl.funct3      = NOP_INSTR[14:12];
        bubble_ctrl.funct7      = NOP_INSTR[31:25];
        bubble_ctrl.alu_op      = alu_add;
        bubble_ctrl.cmp_op      = cmp_beq;
        bubble_ctrl.alumux1_sel = a_rs1;
        bubble_ctrl.alumux2_sel = b_i_imm;
        bubble_ctrl.cmpmux_sel  = cmp_rs2;
        bubble_ctrl.wbmux_sel   = wb_alu;
        bubble_ctrl.reg_write   = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl     <= '0;
            imm      <= '0;
            rs1_data <= '0;
            rs2_data <= '0;
            valid    <= 1'b0;
            mon      <= '0;
        end else if (flush) begin
            ctrl       <= bubble_ctrl;
            imm        <= '0;
            rs1_data   <= '0;
            rs2_data   <= '0;
            valid      <= 1'b0;
            mon        <= '0;
            mon.instr  <= NOP_INSTR;
        end else if (advance) begin
            ctrl          <= ctrl_in;
            imm           <= imm_in;
            rs1_data      <= issue.rs1_data;
            rs2_data      <= issue.rs2_data;
            valid         <= 1'b1;
            mon.commit    <= 1'b1;
            mon.instr     <= issue.instr;
            mon.pc_rdata  <= issue.pc;
            mon.rs1_addr  <= issue.rs1_addr;
            mon.rs2_addr  <= issue.rs2_addr;
            mon.rs1_rdata <= issue.rs1_data;
            mon.rs2_rdata <= issue.rs2_data;
        end else begin
            valid <= 1'b0; // Held entry already consumed.
        end
    end

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  ex_core_pkg::ctrl_word_t      ctrl,
    input  ex_core_pkg::imm_t            imm,
    input  logic [ex_core_pkg::XLEN-1:0] rs1_data,
    input  logic [ex_core_pkg::XLEN-1:0] rs2_data,
    output logic [ex_core_pkg::XLEN-1:0] alu_result
);
    import ex_core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb begin
        if (ctrl.opcode == op_lui) begin
            op_a = '0; // LUI passes u_imm through.
        end else if (ctrl.alumux1_sel == a_pc) begin
            op_a = ctrl.pc;
        end else begin
            op_a = rs1_data;
        end

        case (ctrl.alumux2_sel)
            b_rs2:   op_b = rs2_data;
            b_u_imm: op_b = imm.u_imm;
            b_s_imm: op_b = imm.s_imm;
            b_b_imm: op_b = imm.b_imm;
            default: op_b = imm.i_imm;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

endmodule

// File: logic/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp (
    input  ex_core_pkg::ctrl_word_t      ctrl,
    input  ex_core_pkg::imm_t            imm,
    input  logic [ex_core_pkg::XLEN-1:0] rs1_data,
    input  logic [ex_core_pkg::XLEN-1:0] rs2_data,
    output logic                         cmp_true
);
    import ex_core_pkg::*;

    logic [XLEN-1:0] cmp_b;
    logic            eq;
    logic            lt_s;
    logic            lt_u;

    assign cmp_b = (ctrl.cmpmux_sel == cmp_i_imm) ? imm.i_imm : rs2_data;

    assign eq   = (rs1_data == cmp_b);
    assign lt_s = ($signed(rs1_data) < $signed(cmp_b)); // Signed order.
    assign lt_u = (rs1_data < cmp_b);

    always_comb begin
        case (ctrl.cmp_op)
            cmp_beq:  cmp_true = eq;
            cmp_bne:  cmp_true = !eq;
            cmp_blt:  cmp_true = lt_s;
            cmp_bge:  cmp_true = !lt_s;
            cmp_bltu: cmp_true = lt_u;
            cmp_bgeu: cmp_true = !lt_u;
            default:  cmp_true = 1'b0;
        endcase
    end

endmodule

// File: logic/ex_combine.sv
`timescale 1ns/1ps

module ex_combine (
    input  logic                         clk,
    input  logic                         rst,
    input  ex_core_pkg::ctrl_word_t      ctrl,
    input  ex_core_pkg::imm_t            imm,
    input  logic [ex_core_pkg::XLEN-1:0] rs1_data,
    input  logic                         valid,
    input  logic [ex_core_pkg::XLEN-1:0] alu_result,
    input  logic                         cmp_true,
    input  ex_core_pkg::monitor_t        mon_in,
    output ex_core_pkg::wb_t             wb,
    output ex_core_pkg::redirect_t       redirect,
    output ex_core_pkg::monitor_t        mon
);
    import ex_core_pkg::*;

    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] jalr_sum;
    logic            we;
    logic            taken;

    assign jalr_sum = rs1_data + imm.i_imm;

    always_comb begin
        case (ctrl.wbmux_sel)
            wb_pc4:  wb_data = ctrl.pc + 32'd4;
            wb_cmp:  wb_data = {31'b0, cmp_true};
            default: wb_data = alu_result;
        endcase

        if (ctrl.opcode == op_jalr) begin
            target = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (ctrl.opcode == op_jal) begin
            target = ctrl.pc + imm.j_imm;
        end else begin
            target = alu_result; // Branch, pc+b_imm from the ALU.
        end
    end

    assign we    = valid && ctrl.reg_write && (ctrl.rd != 5'd0);
    assign taken = valid && (ctrl.is_jump || (ctrl.is_branch && cmp_true));

    always_ff @(posedge clk) begin
        wb.rd           <= ctrl.rd;
        wb.data         <= wb_data;
        wb.pc           <= ctrl.pc;
        redirect.target <= target;
        mon             <= mon_in;
        if (rst) begin
            wb.valid       <= 1'b0;
            wb.we          <= 1'b0;
            redirect.taken <= 1'b0;
            mon.commit     <= 1'b0;
        end else begin
            wb.valid       <= valid;
            wb.we          <= we;
            redirect.taken <= taken;
            mon.commit     <= valid && mon_in.commit; // Retire once.
        end
    end

endmodule

// File: logic/ex_core.sv
`timescale 1ns/1ps

module ex_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   flush,
    input  ex_core_pkg::issue_t    issue,
    output ex_core_pkg::wb_t       wb,
    output ex_core_pkg::redirect_t redirect,
    output ex_core_pkg::monitor_t  mon
);
    import ex_core_pkg::*;

    ctrl_word_t      ctrl_dec;
    imm_t            imm_dec;
    ctrl_word_t      ctrl_ex;
    imm_t            imm_ex;
    logic [XLEN-1:0] rs1_ex;
    logic [XLEN-1:0] rs2_ex;
    logic            valid_ex;
    monitor_t        mon_ex;
    logic [XLEN-1:0] alu_result;
    logic            cmp_true;

    instr_decode u_decode (
        .instr (issue.instr),
        .pc    (issue.pc),
        .ctrl  (ctrl_dec),
        .imm   (imm_dec)
    );

    id_ex_reg u_id_ex (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .flush    (flush),
        .issue    (issue),
        .ctrl_in  (ctrl_dec),
        .imm_in   (imm_dec),
        .ctrl     (ctrl_ex),
        .imm      (imm_ex),
        .rs1_data (rs1_ex),
        .rs2_data (rs2_ex),
        .valid    (valid_ex),
        .mon      (mon_ex)
    );

    alu_unit u_alu (
        .ctrl       (ctrl_ex),
        .imm        (imm_ex),
        .rs1_data   (rs1_ex),
        .rs2_data   (rs2_ex),
        .alu_result (alu_result)
    );

    branch_cmp u_cmp (
        .ctrl     (ctrl_ex),
        .imm      (imm_ex),
        .rs1_data (rs1_ex),
        .rs2_data (rs2_ex),
        .cmp_true (cmp_true)
    );

    ex_combine u_combine (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl_ex),
        .imm        (imm_ex),
        .rs1_data   (rs1_ex),
        .valid      (valid_ex),
        .alu_result (alu_result),
        .cmp_true   (cmp_true),
        .mon_in     (mon_ex),
        .wb         (wb),
        .redirect   (redirect),
        .mon        (mon)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // 8 ns period.
        end
    end

endmodule

// File: tb/ex_core_sva.sv
`timescale 1ns/1ps

module ex_core_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   flush,
    input ex_core_pkg::wb_t       wb,
    input ex_core_pkg::redirect_t redirect,
    input ex_core_pkg::monitor_t  mon
);
    import ex_core_pkg::*;

    int fail_count = 0;

    // Outputs quiet during reset and on the edge after it.
    assert property (@(posedge clk) rst |=> (!wb.valid && !wb.we && !redirect.taken && !mon.commit))
        else begin
            $error("Output active right after reset");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) wb.we |-> (wb.rd != 5'd0))
        else begin
            $error("Write enable raised for rd x0");
            fail_count++;
        end

    // Bubble reaches the output two edges after the flush is sampled.
    assert property (@(posedge clk) disable iff (rst)
        flush |-> ##2 (!wb.valid && !wb.we && !redirect.taken))
        else begin
            $error("Flushed slot produced a valid result");
            fail_count++;
        end

    // Only a branch or jump opcode may redirect fetch.
    assert property (@(posedge clk) disable iff (rst)
        redirect.taken |-> (mon.instr[6:0] inside {op_branch, op_jal, op_jalr}))
        else begin
            $error("Redirect taken for an instruction that is no branch or jump");
            fail_count++;
        end

endmodule

bind ex_core ex_core_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .wb       (wb),
    .redirect (redirect),
    .mon      (mon)
);

// File: tb/ex_core_tb.sv
`timescale 1ns/1ps

module ex_core_tb;
    import ex_core_pkg::*;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
    } exp_t;

    logic      clk;
    logic      rst;
    logic      advance;
    logic      flush;
    issue_t    issue;
    wb_t       wb;
    redirect_t redirect;
    monitor_t  mon;

    exp_t        held;    // Model of the ID/EX slot.
    exp_t        pending;
    logic [31:0] cur_pc;
    string       test_name;
    int          test_errors;
    int          test_checks;
    int          total_errors;
    int          failed_tests;
    int          test_count;
    int          cycle_count;
    // Reset, two ALU tests, upper, branch, jump, stall, flush; each with two drain cycles.
    int          test_length = 18 + 42 + 42 + 10 + 32 + 10 + 9 + 9;
    int          cycle_limit = test_length + 200;

    logic [3:0]  alu_ops [0:9] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    logic [2:0]  br_funct3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // Signed and unsigned order disagree on the last three pairs.
    logic [31:0] br_a [0:4] = '{32'd5, 32'd5, 32'hffff_ffff, 32'd1, 32'h8000_0000};
    logic [31:0] br_b [0:4] = '{32'd5, 32'd6, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};

    tb_clock u_clock (.clk(clk));

    ex_core u_dut (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .flush    (flush),
        .issue    (issue),
        .wb       (wb),
        .redirect (redirect),
        .mon      (mon)
    );

    function automatic logic [31:0] encode_fields(input logic [6:0] hi, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {hi, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [11:0] imm12);
        return encode_fields(imm12[11:5], imm12[4:0], 5'd1, 3'd0, rd, op_imm);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm12);
        return {{20{imm12[11]}}, imm12};
    endfunction

    // RV32I semantics, op is {funct7[5], funct3}.
    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
        input logic [31:0] b);
        case (op)
            4'h8:    return a - b;
            4'h1:    return a << b[4:0];
            4'h2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'h3:    return (a < b) ? 32'd1 : 32'd0;
            4'h4:    return a ^ b;
            4'h5:    return a >> b[4:0];
            4'hd:    return $signed(a) >>> b[4:0];
            4'h6:    return a | b;
            4'h7:    return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exp_t expect_result(input logic wr, input logic [4:0] rd,
        input logic [31:0] data, input logic tk, input logic [31:0] target);
        return '{1'b1, wr && (rd != 5'd0), rd, data, tk, target,
            32'd0, 32'd0, 32'd0, 32'd0};
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
        input logic [31:0] actual);
        test_checks++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_output(input exp_t e);
        check_value("wb.valid", e.valid, wb.valid);
        check_value("wb.we", e.we, wb.we);
        check_value("redirect.taken", e.taken, redirect.taken);
        check_value("mon.commit", e.valid, mon.commit);
        if (e.we) begin
            check_value("wb.rd", e.rd, wb.rd);
            check_value("wb.data", e.data, wb.data);
        end
        if (e.taken) begin
            check_value("redirect.target", e.target, redirect.target);
        end
        if (e.valid) begin
            check_value("wb.pc", e.pc, wb.pc);
            check_value("mon.instr", e.instr, mon.instr);
            check_value("mon.pc_rdata", e.pc, mon.pc_rdata);
            check_value("mon.rs1_addr", e.instr[19:15], mon.rs1_addr);
            check_value("mon.rs2_addr", e.instr[24:20], mon.rs2_addr);
            check_value("mon.rs1_rdata", e.rs1_data, mon.rs1_rdata);
            check_value("mon.rs2_rdata", e.rs2_data, mon.rs2_rdata);
        end
    endtask

    // Output now shows the slot held before this edge.
    task automatic tick();
        @(posedge clk);
        #1;
        check_output(held);
        if (rst || flush) begin
            held = '0;
        end else if (advance) begin
            held = pending;
        end else begin
            held = '0; // Stalled entry retires only once.
        end
    endtask

    task automatic drive(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
        input logic adv, input logic fl, input exp_t e);
        issue.instr      = instr;
        issue.pc         = cur_pc;
        issue.rs1_addr   = instr[19:15];
        issue.rs2_addr   = instr[24:20];
        issue.rs1_data   = a;
        issue.rs2_data   = b;
        advance          = adv;
        flush            = fl;
        pending          = e;
        pending.pc       = cur_pc;
        pending.instr    = instr;
        pending.rs1_data = a;
        pending.rs2_data = b;
        tick();
        if (adv && !fl) begin
            cur_pc = cur_pc + 32'd4;
        end
    endtask

    task automatic idle();
        drive($urandom, $urandom, $urandom, 1'b0, 1'b0, '0);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
        test_count++;
    endtask

    task automatic end_test();
        idle();
        idle();
        total_errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %-8s %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [11:0] imm12;
        logic [19:0] u20;
        logic [12:0] bimm;
        logic [20:0] jimm;
        logic [4:0]  rd;
        logic [3:0]  op;
        int          sva_fails;

        void'($urandom(32'h4d0f));
        rst          = 1'b1;
        advance      = 1'b0;
        flush        = 1'b0;
        issue        = '0;
        held         = '0;
        pending      = '0;
        cur_pc       = 32'h0000_1000;
        total_errors = 0;
        failed_tests = 0;
        test_count   = 0;
        begin_test("reset");
        repeat (16) tick();
        rst = 1'b0;
        end_test();

        begin_test("alu_reg");
        repeat (40) begin
            op    = alu_ops[$urandom % 10];
            rd    = 5'($urandom);
            a     = $urandom;
            b     = $urandom;
            instr = encode_fields({1'b0, op[3], 5'd0}, 5'($urandom), 5'($urandom), op[2:0], rd,
                op_reg);
            drive(instr, a, b, 1'b1, 1'b0, expect_result(1'b1, rd, alu_model(op, a, b), 1'b0, 0));
        end
        end_test();

        begin_test("alu_imm");
        repeat (40) begin
            op    = alu_ops[$urandom % 10];
            rd    = 5'($urandom);
            a     = $urandom;
            imm12 = 12'($urandom);
            if (op == 4'h8) begin
                op = 4'h0; // No SUBI.
            end
            if (op[2:0] == 3'd1 || op[2:0] == 3'd5) begin
                imm12 = {1'b0, op[3], 5'd0, imm12[4:0]};
            end
            instr = encode_fields(imm12[11:5], imm12[4:0], 5'($urandom), op[2:0], rd, op_imm);
            drive(instr, a, $urandom, 1'b1, 1'b0,
                expect_result(1'b1, rd, alu_model(op, a, sext12(imm12)), 1'b0, 0));
        end
        end_test();

        begin_test("upper");
        repeat (4) begin
            u20 = 20'($urandom);
            rd  = 5'($urandom);
            drive({u20, rd, op_lui}, $urandom, $urandom, 1'b1, 1'b0,
                expect_result(1'b1, rd, {u20, 12'h000}, 1'b0, 0));
            drive({u20, rd, op_auipc}, $urandom, $urandom, 1'b1, 1'b0,
                expect_result(1'b1, rd, cur_pc + {u20, 12'h000}, 1'b0, 0));
        end
        end_test();

        begin_test("branch");
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 5; j++) begin
                bimm  = {12'($urandom), 1'b0};
                instr = {bimm[12], bimm[10:5], 5'($urandom), 5'($urandom), br_funct3[i],
                    bimm[4:1], bimm[11], op_branch};
                drive(instr, br_a[j], br_b[j], 1'b1, 1'b0,
                    expect_result(1'b0, 5'd0, 0, branch_model(br_funct3[i], br_a[j], br_b[j]),
                    cur_pc + {{19{bimm[12]}}, bimm}));
            end
        end
        end_test();

        begin_test("jump");
        repeat (4) begin
            jimm  = {20'($urandom), 1'b0};
            rd    = 5'($urandom);
            instr = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, op_jal};
            drive(instr, $urandom, $urandom, 1'b1, 1'b0,
                expect_result(1'b1, rd, cur_pc + 32'd4, 1'b1, cur_pc + {{11{jimm[20]}}, jimm}));
        end
        repeat (4) begin
            imm12 = 12'($urandom);
            rd    = 5'($urandom);
            a     = $urandom;
            sum   = a + sext12(imm12);
            if (!sum[0]) begin
                a   = a ^ 32'd1; // Odd sum, so bit 0 has to be cleared.
                sum = a + sext12(imm12);
            end
            instr = encode_fields(imm12[11:5], imm12[4:0], 5'($urandom), 3'd0, rd, op_jalr);
            drive(instr, a, $urandom, 1'b1, 1'b0,
                expect_result(1'b1, rd, cur_pc + 32'd4, 1'b1, {sum[31:1], 1'b0}));
        end
        end_test();

        begin_test("stall");
        a     = $urandom;
        imm12 = 12'($urandom);
        drive(addi(5'd7, imm12), a, 0, 1'b1, 1'b0,
            expect_result(1'b1, 5'd7, a + sext12(imm12), 1'b0, 0));
        repeat (5) idle();
        a = $urandom;
        drive(addi(5'd8, imm12), a, 0, 1'b1, 1'b0,
            expect_result(1'b1, 5'd8, a + sext12(imm12), 1'b0, 0));
        end_test();

        begin_test("flush");
        drive(addi(5'd5, 12'h123), 32'h10, 0, 1'b1, 1'b1, '0);
        jimm = {20'($urandom), 1'b0};
        drive({jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd1, op_jal}, 0, 0, 1'b1, 1'b1, '0);
        a = $urandom;
        drive(addi(5'd6, 12'h7ff), a, 0, 1'b1, 1'b0,
            expect_result(1'b1, 5'd6, a + 32'h7ff, 1'b0, 0));
        drive(addi(5'd6, 12'h001), a, 0, 1'b0, 1'b1, '0); // Loaded one still retires.
        drive(addi(5'd0, 12'h055), a, 0, 1'b1, 1'b0,
            expect_result(1'b1, 5'd0, a + 32'h55, 1'b0, 0));
        drive(encode_fields(7'h12, 5'd9, 5'd4, 3'd2, 5'd3, op_store), $urandom, $urandom,
            1'b1, 1'b0, expect_result(1'b0, 5'd3, 0, 1'b0, 0));
        drive(encode_fields(7'h02, 5'd0, 5'd4, 3'd2, 5'd9, op_load), $urandom, $urandom,
            1'b1, 1'b0, expect_result(1'b0, 5'd9, 0, 1'b0, 0));
        end_test();

        sva_fails = u_dut.u_sva.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
            test_count, failed_tests, total_errors, sva_fails);
        if (total_errors == 0 && sva_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: ex_core.f
logic/ex_core_pkg.sv
logic/instr_decode.sv
logic/id_ex_reg.sv
logic/alu_unit.sv
logic/branch_cmp.sv
logic/ex_combine.sv
logic/ex_core.sv
tb/tb_clock.sv
tb/ex_core_sva.sv
tb/ex_core_tb.sv

// File: Bender.yml
package:
  name: ex_core

sources:
  - logic/ex_core_pkg.sv
  - logic/instr_decode.sv
  - logic/id_ex_reg.sv
  - logic/alu_unit.sv
  - logic/branch_cmp.sv
  - logic/ex_combine.sv
  - logic/ex_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/ex_core_sva.sv
      - tb/ex_core_tb.sv
